// ==== list.f ====
hw/sipo_pkg.sv
hw/button_handler.sv
hw/frame_counter.sv
hw/sipo_controller.sv
hw/sipo_shift_register.sv
hw/sipo_capture_top.sv
sim/tb_sipo_capture.sv

// ==== Bender.yml ====
package:
  name: sipo_capture

sources:
  - files:
      - hw/sipo_pkg.sv
      - hw/button_handler.sv
      - hw/frame_counter.sv
      - hw/sipo_controller.sv
      - hw/sipo_shift_register.sv
      - hw/sipo_capture_top.sv
  - target: simulation
    files:
      - sim/tb_sipo_capture.sv

// ==== sim/tb_sipo_capture.sv ====
`timescale 1ns/100ps

module tb_sipo_capture;

    import sipo_pkg::*;

    localparam int frame_bits       = int'(default_frame_stop - default_frame_start) + 1;
    localparam int n_rows           = 7;
    localparam int clk_period       = 20;
    localparam int reset_cycles     = 5;
    localparam int max_phase_cycles = 40;
    localparam int margin_cycles    = 64;
    localparam int ready_timeout    = 48;
    localparam int watchdog_cycles  =
        n_rows * (reset_cycles + 2 * max_phase_cycles + int'(default_frame_stop) + margin_cycles);

    logic                  clk;
    logic                  reset_b;
    logic                  button;
    logic                  serial_data;
    logic                  sample_strobe;
    logic                  frame_ready;
    logic [frame_bits-1:0] frame_data;

    // stimulus and expected values, one entry per row.
    string                 test_name    [n_rows];
    int                    press_len    [n_rows];
    int                    rel_len      [n_rows];
    logic [frame_bits-1:0] frame_word   [n_rows];
    bit                    second_press [n_rows];
    bit                    exp_ready    [n_rows];
    logic [frame_bits-1:0] exp_frame    [n_rows];

    integer                seed;
    int                    error_count;
    string                 current_name;
    logic [frame_bits-1:0] row_word;
    int                    bit_idx;
    int                    strobe_count;
    logic                  strobe_seen;

    sipo_capture_top UUT (
        .clk           (clk),
        .reset_b       (reset_b),
        .button        (button),
        .serial_data   (serial_data),
        .sample_strobe (sample_strobe),
        .frame_ready   (frame_ready),
        .frame_data    (frame_data)
    );

    initial
    begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // strobe level taken mid cycle, well away from the edges.
    always @(negedge clk)
    begin
        strobe_seen = sample_strobe;
        if (reset_b && frame_ready && sample_strobe)
        begin
            $display("error: sample_strobe high while frame_ready high in test %s",
                     current_name);
            error_count = error_count + 1;
        end
    end

    // serial source model, msb first, next bit after each strobed edge.
    always @(posedge clk)
    begin
        if (strobe_seen)
        begin
            strobe_count = strobe_count + 1;
            #2;
            bit_idx = bit_idx - 1;
            if (bit_idx >= 0)
            begin
                serial_data = row_word[bit_idx];
            end
            else
            begin
                serial_data = 1'b0;
            end
        end
    end

    initial
    begin
        #(watchdog_cycles * clk_period);
        $display("error: run hung, watchdog expired after %0d cycles", watchdog_cycles);
        $display("Test FAILED");
        $finish;
    end

    task automatic set_row(input int idx, input string name, input int press,
                           input int rel, input logic [frame_bits-1:0] word,
                           input bit second, input bit ready);
        test_name[idx]    = name;
        press_len[idx]    = press;
        rel_len[idx]      = rel;
        frame_word[idx]   = word;
        second_press[idx] = second;
        exp_ready[idx]    = ready;
        // msb goes out first and lands in the msb, so a capture returns the word.
        exp_frame[idx]    = ready ? word : '0;
    endtask

    task automatic load_table();
        logic [31:0] rnd_a;
        logic [31:0] rnd_b;

        rnd_a = $random(seed);
        rnd_b = $random(seed);
        set_row(0, "all_zeros",   20, 20, 12'h000, 1'b0, 1'b1);
        set_row(1, "all_ones",    20, 20, 12'hfff, 1'b1, 1'b1);
        set_row(2, "alternating", 24, 22, 12'haaa, 1'b1, 1'b1);
        set_row(3, "one_hot",     20, 30, 12'h800, 1'b0, 1'b1);
        set_row(4, "short_press",  8, 20, 12'h5a5, 1'b0, 1'b0);
        set_row(5, "random_a",    20, 20, rnd_a[frame_bits-1:0], 1'b1, 1'b1);
        set_row(6, "random_b",    28, 20, rnd_b[frame_bits-1:0], 1'b0, 1'b1);
    endtask

    task automatic compare_value(input string what, input logic [31:0] expected,
                                 input logic [31:0] actual);
        if (expected !== actual)
        begin
            $display("mismatch: test %s, %s expected %h actual %h",
                     current_name, what, expected, actual);
            error_count = error_count + 1;
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        #2;
        reset_b = 1'b0;
        button  = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        #2;
        reset_b = 1'b1;
    endtask

    task automatic press_button(input int high_cycles, input int low_cycles);
        button = 1'b1;
        repeat (high_cycles) @(posedge clk);
        #2;
        button = 1'b0;
        repeat (low_cycles) @(posedge clk);
        #2;
    endtask

    task automatic wait_ready(output bit seen);
        int cycles;

        seen   = 1'b0;
        cycles = 0;
        while (!seen && cycles < ready_timeout)
        begin
            if (frame_ready)
            begin
                seen = 1'b1;
            end
            else
            begin
                @(posedge clk);
                #2;
                cycles = cycles + 1;
            end
        end
    endtask

    task automatic run_row(input int idx);
        bit seen;

        current_name = test_name[idx];
        apply_reset();
        compare_value("reset frame_ready", 32'd0, 32'(frame_ready));
        compare_value("reset sample_strobe", 32'd0, 32'(sample_strobe));
        compare_value("reset frame_data", 32'd0, 32'(frame_data));

        row_word     = frame_word[idx];
        bit_idx      = frame_bits - 1;
        serial_data  = row_word[frame_bits-1];
        strobe_count = 0;

        press_button(press_len[idx], rel_len[idx]);
        wait_ready(seen);
        if (exp_ready[idx] && !seen)
        begin
            $display("error: frame_ready did not rise within %0d cycles in test %s",
                     ready_timeout, current_name);
            error_count = error_count + 1;
        end
        else if (!exp_ready[idx] && seen)
        begin
            $display("error: frame_ready rose after a short press in test %s",
                     current_name);
            error_count = error_count + 1;
        end
        compare_value("frame_ready", 32'(exp_ready[idx]), 32'(frame_ready));
        compare_value("frame_data", 32'(exp_frame[idx]), 32'(frame_data));
        compare_value("strobe count", exp_ready[idx] ? frame_bits : 0, strobe_count);

        if (second_press[idx])
        begin
            press_button(20, 20);
            repeat (ready_timeout) @(posedge clk);
            #2;
            compare_value("held frame_ready", 32'd1, 32'(frame_ready));
            compare_value("held frame_data", 32'(exp_frame[idx]), 32'(frame_data));
            compare_value("held strobe count", frame_bits, strobe_count);
        end
    endtask

    initial
    begin
        reset_b      = 1'b0;
        button       = 1'b0;
        serial_data  = 1'b0;
        strobe_seen  = 1'b0;
        strobe_count = 0;
        bit_idx      = 0;
        row_word     = '0;
        error_count  = 0;
        current_name = "init";
        seed         = 3;

        load_table();
        for (int i = 0; i < n_rows; i++)
        begin
            run_row(i);
        end

        $display("checks done, %0d errors", error_count);
        if (error_count == 0)
        begin
            $display("Test OK");
        end
        else
        begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

// ==== hw/sipo_capture_top.sv ====
`timescale 1ns/100ps

module sipo_capture_top #(
    parameter logic [sipo_pkg::counter_width-1:0] frame_start = sipo_pkg::default_frame_start,
    parameter logic [sipo_pkg::counter_width-1:0] frame_stop  = sipo_pkg::default_frame_stop,
    parameter logic [15:0] debounce_cycles = sipo_pkg::default_debounce_cycles,
    localparam int frame_bits = int'(frame_stop - frame_start) + 1
) (
    input  logic                  clk,
    input  logic                  reset_b,
    input  logic                  button,
    input  logic                  serial_data,
    output logic                  sample_strobe,
    output logic                  frame_ready,
    output logic [frame_bits-1:0] frame_data
);

    import sipo_pkg::*;

    logic                     control_signal;
    logic [1:0]               counter_sel;
    logic [counter_width-1:0] counter_value;
    logic                     data_logging;
    logic                     data_ready;

    assign sample_strobe = data_logging;
    assign frame_ready   = data_ready;

    button_handler #(
        .debounce_cycles(debounce_cycles)
    ) u_button (
        .clk            (clk),
        .reset_b        (reset_b),
        .button         (button),
        .control_signal (control_signal)
    );

    sipo_controller #(
        .frame_start(frame_start),
        .frame_stop (frame_stop)
    ) u_ctrl (
        .clk            (clk),
        .reset_b        (reset_b),
        .control_signal (control_signal),
        .counter_value  (counter_value),
        .data_logging   (data_logging),
        .data_ready     (data_ready),
        .counter_sel    (counter_sel)
    );

    frame_counter u_count (
        .clk           (clk),
        .reset_b       (reset_b),
        .counter_sel   (counter_sel),
        .counter_value (counter_value)
    );

    // one bit per clock while the window is open.
    sipo_shift_register #(
        .frame_bits(frame_bits)
    ) u_sipo (
        .clk          (clk),
        .reset_b      (reset_b),
        .data_logging (data_logging),
        .serial_data  (serial_data),
        .frame_data   (frame_data)
    );

endmodule

// ==== hw/sipo_shift_register.sv ====
`timescale 1ns/100ps

module sipo_shift_register #(
    parameter int frame_bits = 12
) (
    input  logic                  clk,
    input  logic                  reset_b,
    input  logic                  data_logging,
    input  logic                  serial_data,
    output logic [frame_bits-1:0] frame_data
);

    // first bit in ends up as the msb.
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            frame_data <= '0;
        end
        else if (data_logging)
        begin
            frame_data <= {frame_data[frame_bits-2:0], serial_data};
        end
    end

    if (frame_bits > 1)
    begin : g_shift_check
        localparam int tally_width = $clog2(frame_bits + 2);

        logic [tally_width-1:0] shift_tally;

        // shifts taken since reset.
        always_ff @(posedge clk or negedge reset_b)
        begin
            if (!reset_b)
            begin
                shift_tally <= '0;
            end
            else if (data_logging && (shift_tally <= tally_width'(frame_bits)))
            begin
                shift_tally <= shift_tally + 1'b1;
            end
        end

        // the window closes after one frame and stays closed.
        a_frame_bits_only : assert property (
            @(posedge clk) disable iff (!reset_b)
            data_logging |-> (shift_tally < tally_width'(frame_bits))
        );
    end

endmodule

// ==== hw/sipo_controller.sv ====
`timescale 1ns/100ps

module sipo_controller #(
    parameter logic [sipo_pkg::counter_width-1:0] frame_start = sipo_pkg::default_frame_start,
    parameter logic [sipo_pkg::counter_width-1:0] frame_stop  = sipo_pkg::default_frame_stop
) (
    input  logic                               clk,
    input  logic                               reset_b,
    input  logic                               control_signal,
    input  logic [sipo_pkg::counter_width-1:0] counter_value,
    output logic                               data_logging,
    output logic                               data_ready,
    output logic [1:0]                         counter_sel
);

    import sipo_pkg::*;

    localparam logic [2:0] st_idle    = 3'd0;
    localparam logic [2:0] st_pressed = 3'd1;
    localparam logic [2:0] st_wait    = 3'd2;
    localparam logic [2:0] st_log     = 3'd3;
    localparam logic [2:0] st_done    = 3'd4;

    logic [2:0] state;
    logic [2:0] next_state;

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            state <= st_idle;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        counter_sel  = cnt_clear;
        data_logging = 1'b0;
        data_ready   = 1'b0;
        next_state   = st_idle;

        case (state)
            st_idle:
            begin
                if (control_signal)
                begin
                    next_state = st_pressed;
                end
                else
                begin
                    next_state = st_idle;
                end
            end
            st_pressed:
            begin
                // armed, waiting for the release.
                if (control_signal)
                begin
                    next_state = st_pressed;
                end
                else
                begin
                    next_state = st_wait;
                end
            end
            st_wait:
            begin
                counter_sel = cnt_count;
                // first logging cycle sees count frame_start.
                if (counter_value == frame_start - 1'b1)
                begin
                    next_state = st_log;
                end
                else
                begin
                    next_state = st_wait;
                end
            end
            st_log:
            begin
                counter_sel  = cnt_count;
                data_logging = 1'b1;
                if (counter_value == frame_stop)
                begin
                    next_state = st_done;
                end
                else
                begin
                    next_state = st_log;
                end
            end
            st_done:
            begin
                // held until reset.
                counter_sel = cnt_hold;
                data_ready  = 1'b1;
                next_state  = st_done;
            end
            default:
            begin
                next_state = st_idle;
            end
        endcase
    end

    a_log_ready_exclusive : assert property (
        @(posedge clk) disable iff (!reset_b)
        !(data_logging && data_ready)
    );

    a_no_spare_select : assert property (
        @(posedge clk) disable iff (!reset_b)
        counter_sel != cnt_unused
    );

endmodule

// ==== hw/frame_counter.sv ====
`timescale 1ns/100ps

module frame_counter (
    input  logic                               clk,
    input  logic                               reset_b,
    input  logic [1:0]                         counter_sel,
    output logic [sipo_pkg::counter_width-1:0] counter_value
);

    import sipo_pkg::*;

    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            counter_value <= '0;
        end
        else
        begin
            case (counter_sel)
                cnt_clear:
                begin
                    counter_value <= '0;
                end
                cnt_count:
                begin
                    // saturate at all ones.
                    if (counter_value != '1)
                    begin
                        counter_value <= counter_value + 1'b1;
                    end
                end
                default:
                begin
                    // cnt_hold and the spare code.
                    counter_value <= counter_value;
                end
            endcase
        end
    end

    // controller must stop counting long before overflow.
    a_no_saturation : assert property (
        @(posedge clk) disable iff (!reset_b)
        (counter_sel == cnt_count) |-> (counter_value != '1)
    );

endmodule

// ==== hw/button_handler.sv ====
`timescale 1ns/100ps

module button_handler #(
    parameter logic [15:0] debounce_cycles = sipo_pkg::default_debounce_cycles
) (
    input  logic clk,
    input  logic reset_b,
    input  logic button,
    output logic control_signal
);

    import sipo_pkg::*;

    logic [sync_stages-1:0] sync_q;
    logic                   button_sync;
    logic [15:0]            stable_cnt;

    // button is asynchronous to clk.
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            sync_q <= '0;
        end
        else
        begin
            sync_q <= {sync_q[sync_stages-2:0], button};
        end
    end

    assign button_sync = sync_q[sync_stages-1];

    // counts down while the synced button differs from the output level.
    // any return to the old level reloads the count.
    always_ff @(posedge clk or negedge reset_b)
    begin
        if (!reset_b)
        begin
            stable_cnt     <= debounce_cycles - 16'd1;
            control_signal <= 1'b0;
        end
        else if (button_sync == control_signal)
        begin
            stable_cnt <= debounce_cycles - 16'd1;
        end
        else if (stable_cnt == 16'd0)
        begin
            control_signal <= button_sync;
            stable_cnt     <= debounce_cycles - 16'd1;
        end
        else
        begin
            stable_cnt <= stable_cnt - 16'd1;
        end
    end

    // a new level must be held a full debounce period.
    a_no_back_to_back_change : assert property (
        @(posedge clk) disable iff (!reset_b)
        $changed(control_signal) |=> !$changed(control_signal)
    );

endmodule

// ==== hw/sipo_pkg.sv ====
package sipo_pkg;

    // width of the cycle count.
    localparam int counter_width = 20;

    // frame counter select codes.
    localparam logic [1:0] cnt_clear  = 2'd0;
    localparam logic [1:0] cnt_unused = 2'd1;
    localparam logic [1:0] cnt_hold   = 2'd2;
    localparam logic [1:0] cnt_count  = 2'd3;

    // logging window, inclusive on both ends.
    localparam logic [counter_width-1:0] default_frame_start = 20'd3;
    localparam logic [counter_width-1:0] default_frame_stop  = 20'd14;

    // stable clocks needed before the button level is accepted.
    localparam logic [15:0] default_debounce_cycles = 16'd16;

    // flops in the button synchronizer.
    localparam int sync_stages = 2;

endpackage
